//--- src/rvPkg.sv
package rvPkg;

    localparam int xlen = 32;
    localparam int imemDepth = 64;
    localparam int dmemDepth = 64;

    // major opcodes of the supported subset
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opI      = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;

    // addi x0, x0, 0
    localparam logic [31:0] nopInstr = 32'h0000_0013;

    // operand sources in execute
    localparam logic [1:0] fwdReg = 2'b00;
    localparam logic [1:0] fwdWb  = 2'b01;
    localparam logic [1:0] fwdMem = 2'b10;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt,
        aluSltu, aluSll, aluSrl, aluSra, aluPassB
    } aluOpT;

    typedef enum logic [1:0] {
        resAlu, resLoad, resPc4, resImm
    } resultSrcT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
        jTypeT jType;
    } instrT;

endpackage

//--- src/pipeIf.sv
`timescale 1ns/1ps

interface fetchDecodeIf;
    rvPkg::instrT           instr;
    logic [rvPkg::xlen-1:0] pc;
    logic [rvPkg::xlen-1:0] pcPlus4;

    modport source (output instr, pc, pcPlus4);
    modport sink (input instr, pc, pcPlus4);
endinterface

interface decodeExecIf;
    logic [rvPkg::xlen-1:0] rs1Data, rs2Data, imm, pc, pcPlus4;
    logic [4:0]             rs1, rs2, rd;
    logic [2:0]             funct3;
    rvPkg::aluOpT           aluOp;
    rvPkg::resultSrcT       resultSrc;
    logic                   aluSrc, regWrite, memWrite, branch, jump, jalr;

    modport source (output rs1Data, rs2Data, rs1, rs2, rd, imm, pc, pcPlus4, funct3,
                    aluOp, aluSrc, regWrite, memWrite, resultSrc, branch, jump, jalr);
    modport sink (input rs1Data, rs2Data, rs1, rs2, rd, imm, pc, pcPlus4, funct3,
                  aluOp, aluSrc, regWrite, memWrite, resultSrc, branch, jump, jalr);
endinterface

interface execMemIf;
    logic [rvPkg::xlen-1:0] aluResult, writeData, imm, pcPlus4;
    logic [4:0]             rd;
    logic                   regWrite, memWrite;
    rvPkg::resultSrcT       resultSrc;

    modport source (output aluResult, writeData, imm, pcPlus4, rd, regWrite, memWrite,
                    resultSrc);
    modport sink (input aluResult, writeData, imm, pcPlus4, rd, regWrite, memWrite,
                  resultSrc);
endinterface

interface memWbIf;
    logic [rvPkg::xlen-1:0] result;
    logic [4:0]             rd;
    logic                   regWrite;

    modport source (output result, rd, regWrite);
    modport sink (input result, rd, regWrite);
endinterface

//--- src/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   progWe,
    input  logic [5:0]             progAddr,
    input  logic [31:0]            progData,
    input  logic                   stallF,
    input  logic                   stallD,
    input  logic                   flushD,
    input  logic                   pcSrc,
    input  logic [rvPkg::xlen-1:0] pcTarget,
    fetchDecodeIf.source           fd
);

    logic [rvPkg::xlen-1:0] pc;
    logic [rvPkg::xlen-1:0] pcPlus4;
    rvPkg::instrT           imem [rvPkg::imemDepth];

    assign pcPlus4 = pc + 32'd4;

    // program port is the only write path
    always_ff @(posedge clk) begin
        if (progWe)
            imem[progAddr] <= progData;
    end

    // a resolved jump wins over the load-use hold
    always_ff @(posedge clk) begin
        if (!rstN)
            pc <= '0;
        else if (pcSrc)
            pc <= pcTarget;
        else if (!stallF)
            pc <= pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (!rstN || flushD)
            fd.instr <= rvPkg::nopInstr;
        else if (!stallD)
            fd.instr <= imem[pc[7:2]];
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            fd.pc      <= pc;
            fd.pcPlus4 <= pcPlus4;
        end
    end

endmodule

//--- src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic         clk,
    input  logic         rstN,
    input  logic         stallD,
    input  logic         flushE,
    fetchDecodeIf.sink   fd,
    memWbIf.sink         wb,
    decodeExecIf.source  de,
    output logic [4:0]   rs1D,
    output logic [4:0]   rs2D
);

    logic [rvPkg::xlen-1:0] regs [32];
    logic [rvPkg::xlen-1:0] rs1Val, rs2Val, immD;
    logic                   regWriteD, memWriteD, branchD, jumpD, jalrD, aluSrcD;
    logic                   bubble;
    rvPkg::aluOpT           aluOpD;
    rvPkg::resultSrcT       resultSrcD;

    function automatic rvPkg::aluOpT aluDecode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  aluDecode = alt ? rvPkg::aluSub : rvPkg::aluAdd;
            3'b001:  aluDecode = rvPkg::aluSll;
            3'b010:  aluDecode = rvPkg::aluSlt;
            3'b011:  aluDecode = rvPkg::aluSltu;
            3'b100:  aluDecode = rvPkg::aluXor;
            3'b101:  aluDecode = alt ? rvPkg::aluSra : rvPkg::aluSrl;
            3'b110:  aluDecode = rvPkg::aluOr;
            default: aluDecode = rvPkg::aluAnd;
        endcase
    endfunction

    // x0 reads zero, a write in the same cycle is seen first
    function automatic logic [rvPkg::xlen-1:0] readReg(input logic [4:0] addr);
        if (addr == 5'd0)
            readReg = '0;
        else if (wb.regWrite && wb.rd == addr)
            readReg = wb.result;
        else
            readReg = regs[addr];
    endfunction

    assign rs1D = fd.instr.rType.rs1;
    assign rs2D = fd.instr.rType.rs2;

    always_comb begin
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        branchD    = 1'b0;
        jumpD      = 1'b0;
        jalrD      = 1'b0;
        aluSrcD    = 1'b0;
        aluOpD     = rvPkg::aluAdd;
        resultSrcD = rvPkg::resAlu;
        immD       = '0;
        case (fd.instr.rType.opcode)
            rvPkg::opR: begin
                regWriteD = 1'b1;
                aluOpD    = aluDecode(fd.instr.rType.funct3, fd.instr.rType.funct7[5]);
            end
            rvPkg::opI: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                // only srai uses the alternate bit, addi has no subtract form
                aluOpD    = aluDecode(fd.instr.iType.funct3,
                                      fd.instr.iType.funct3 == 3'b101 && fd.instr.rType.funct7[5]);
                immD      = {{20{fd.instr.iType.imm[11]}}, fd.instr.iType.imm};
            end
            rvPkg::opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = rvPkg::resLoad;
                immD       = {{20{fd.instr.iType.imm[11]}}, fd.instr.iType.imm};
            end
            rvPkg::opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immD      = {{20{fd.instr.sType.immHi[6]}}, fd.instr.sType.immHi,
                             fd.instr.sType.immLo};
            end
            rvPkg::opBranch: begin
                branchD = 1'b1;
                aluOpD  = rvPkg::aluSub;
                immD    = {{19{fd.instr.bType.imm12}}, fd.instr.bType.imm12,
                           fd.instr.bType.imm11, fd.instr.bType.imm10_5,
                           fd.instr.bType.imm4_1, 1'b0};
            end
            rvPkg::opJal: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                resultSrcD = rvPkg::resPc4;
                immD       = {{11{fd.instr.jType.imm20}}, fd.instr.jType.imm20,
                              fd.instr.jType.imm19_12, fd.instr.jType.imm11,
                              fd.instr.jType.imm10_1, 1'b0};
            end
            rvPkg::opJalr: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                jalrD      = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = rvPkg::resPc4;
                immD       = {{20{fd.instr.iType.imm[11]}}, fd.instr.iType.imm};
            end
            rvPkg::opLui: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                aluOpD     = rvPkg::aluPassB;
                resultSrcD = rvPkg::resImm;
                // upper immediate straight from the raw word
                immD       = {fd.instr[31:12], 12'b0};
            end
            default: ;
        endcase
    end

    always_comb begin
        rs1Val = readReg(rs1D);
        rs2Val = readReg(rs2D);
    end

    always_ff @(posedge clk) begin
        if (wb.regWrite && wb.rd != 5'd0)
            regs[wb.rd] <= wb.result;
    end

    // a stalled decode must not also move into execute
    assign bubble = flushE || stallD;

    always_ff @(posedge clk) begin
        if (!rstN || bubble) begin
            de.regWrite <= 1'b0;
            de.memWrite <= 1'b0;
            de.branch   <= 1'b0;
            de.jump     <= 1'b0;
            de.jalr     <= 1'b0;
        end else begin
            de.regWrite <= regWriteD;
            de.memWrite <= memWriteD;
            de.branch   <= branchD;
            de.jump     <= jumpD;
            de.jalr     <= jalrD;
        end
    end

    always_ff @(posedge clk) begin
        de.rs1Data   <= rs1Val;
        de.rs2Data   <= rs2Val;
        de.rs1       <= rs1D;
        de.rs2       <= rs2D;
        de.rd        <= fd.instr.rType.rd;
        de.imm       <= immD;
        de.pc        <= fd.pc;
        de.pcPlus4   <= fd.pcPlus4;
        de.funct3    <= fd.instr.rType.funct3;
        de.aluOp     <= aluOpD;
        de.aluSrc    <= aluSrcD;
        de.resultSrc <= resultSrcD;
    end

endmodule

//--- src/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                   clk,
    input  logic                   rstN,
    decodeExecIf.sink              de,
    input  logic [1:0]             forwardA,
    input  logic [1:0]             forwardB,
    memWbIf.sink                   wb,
    execMemIf.source               em,
    output logic                   pcSrc,
    output logic [rvPkg::xlen-1:0] pcTarget
);

    logic [rvPkg::xlen-1:0] memFwd, srcA, fwdB, srcB, aluResult;
    logic                   zero, signedLess, unsignedLess, taken;

    function automatic logic [rvPkg::xlen-1:0] pickOperand(
        input logic [1:0]             sel,
        input logic [rvPkg::xlen-1:0] regVal,
        input logic [rvPkg::xlen-1:0] wbVal,
        input logic [rvPkg::xlen-1:0] memVal
    );
        case (sel)
            rvPkg::fwdWb:  pickOperand = wbVal;
            rvPkg::fwdMem: pickOperand = memVal;
            default:       pickOperand = regVal;
        endcase
    endfunction

    // jal, jalr and lui in memory hold their rd value outside aluResult
    always_comb begin
        case (em.resultSrc)
            rvPkg::resPc4: memFwd = em.pcPlus4;
            rvPkg::resImm: memFwd = em.imm;
            default:       memFwd = em.aluResult;
        endcase
    end

    assign srcA = pickOperand(forwardA, de.rs1Data, wb.result, memFwd);
    assign fwdB = pickOperand(forwardB, de.rs2Data, wb.result, memFwd);
    assign srcB = de.aluSrc ? de.imm : fwdB;

    assign signedLess   = $signed(srcA) < $signed(srcB);
    assign unsignedLess = srcA < srcB;

    always_comb begin
        case (de.aluOp)
            rvPkg::aluSub:   aluResult = srcA - srcB;
            rvPkg::aluAnd:   aluResult = srcA & srcB;
            rvPkg::aluOr:    aluResult = srcA | srcB;
            rvPkg::aluXor:   aluResult = srcA ^ srcB;
            rvPkg::aluSlt:   aluResult = {31'b0, signedLess};
            rvPkg::aluSltu:  aluResult = {31'b0, unsignedLess};
            rvPkg::aluSll:   aluResult = srcA << srcB[4:0];
            rvPkg::aluSrl:   aluResult = srcA >> srcB[4:0];
            rvPkg::aluSra:   aluResult = $signed(srcA) >>> srcB[4:0];
            rvPkg::aluPassB: aluResult = srcB;
            default:         aluResult = srcA + srcB;
        endcase
    end

    // branches run the ALU as a subtract
    assign zero = aluResult == '0;

    always_comb begin
        case (de.funct3)
            3'b000:  taken = zero;
            3'b001:  taken = !zero;
            3'b100:  taken = signedLess;
            3'b101:  taken = !signedLess;
            default: taken = 1'b0;
        endcase
    end

    assign pcSrc    = de.jump || (de.branch && taken);
    assign pcTarget = de.jalr ? {aluResult[31:1], 1'b0} : de.pc + de.imm;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            em.regWrite <= 1'b0;
            em.memWrite <= 1'b0;
        end else begin
            em.regWrite <= de.regWrite;
            em.memWrite <= de.memWrite;
        end
    end

    always_ff @(posedge clk) begin
        em.aluResult <= aluResult;
        em.writeData <= fwdB;
        em.imm       <= de.imm;
        em.pcPlus4   <= de.pcPlus4;
        em.rd        <= de.rd;
        em.resultSrc <= de.resultSrc;
    end

endmodule

//--- src/memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
    input  logic    clk,
    input  logic    rstN,
    execMemIf.sink  em,
    memWbIf.source  wb
);

    logic [rvPkg::xlen-1:0] dmem [rvPkg::dmemDepth];
    logic [rvPkg::xlen-1:0] readData;
    logic [rvPkg::xlen-1:0] resultM;

    // word addressed, byte offset ignored
    always_ff @(posedge clk) begin
        if (em.memWrite)
            dmem[em.aluResult[7:2]] <= em.writeData;
    end

    assign readData = dmem[em.aluResult[7:2]];

    always_comb begin
        case (em.resultSrc)
            rvPkg::resLoad: resultM = readData;
            rvPkg::resPc4:  resultM = em.pcPlus4;
            rvPkg::resImm:  resultM = em.imm;
            default:        resultM = em.aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            wb.regWrite <= 1'b0;
        else
            wb.regWrite <= em.regWrite;
    end

    always_ff @(posedge clk) begin
        wb.result <= resultM;
        wb.rd     <= em.rd;
    end

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  logic [4:0]  rs1D,
    input  logic [4:0]  rs2D,
    decodeExecIf.sink   de,
    execMemIf.sink      em,
    memWbIf.sink        wb,
    input  logic        pcSrc,
    output logic [1:0]  forwardA,
    output logic [1:0]  forwardB,
    output logic        stallF,
    output logic        stallD,
    output logic        flushD,
    output logic        flushE
);

    logic loadUse;

    // newest producer first, x0 never forwarded
    function automatic logic [1:0] fwdFor(input logic [4:0] rs);
        if (rs != 5'd0 && em.regWrite && em.rd == rs)
            fwdFor = rvPkg::fwdMem;
        else if (rs != 5'd0 && wb.regWrite && wb.rd == rs)
            fwdFor = rvPkg::fwdWb;
        else
            fwdFor = rvPkg::fwdReg;
    endfunction

    always_comb begin
        forwardA = fwdFor(de.rs1);
        forwardB = fwdFor(de.rs2);
    end

    assign loadUse = de.regWrite && de.resultSrc == rvPkg::resLoad && de.rd != 5'd0
                     && (de.rd == rs1D || de.rd == rs2D);

    assign stallF = loadUse;
    assign stallD = loadUse;
    assign flushD = pcSrc;
    // bubble into execute while decode waits
    assign flushE = pcSrc || loadUse;

endmodule

//--- src/riscvCore.sv
`timescale 1ns/1ps

module riscvCore (
    input  logic        clk,
    input  logic        rstN,
    input  logic        progWe,
    input  logic [5:0]  progAddr,
    input  logic [31:0] progData,
    output logic        wbValid,
    output logic [4:0]  wbRd,
    output logic [31:0] wbData
);

    logic [rvPkg::xlen-1:0] pcTarget;
    logic [4:0]             rs1D, rs2D;
    logic [1:0]             forwardA, forwardB;
    logic                   pcSrc, stallF, stallD, flushD, flushE;

    fetchDecodeIf fd ();
    decodeExecIf  de ();
    execMemIf     em ();
    memWbIf       wb ();

    fetchStage uFetch (
        .clk(clk), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .stallF(stallF), .stallD(stallD), .flushD(flushD),
        .pcSrc(pcSrc), .pcTarget(pcTarget), .fd(fd)
    );

    decodeStage uDecode (
        .clk(clk), .rstN(rstN), .stallD(stallD), .flushE(flushE),
        .fd(fd), .wb(wb), .de(de), .rs1D(rs1D), .rs2D(rs2D)
    );

    executeStage uExecute (
        .clk(clk), .rstN(rstN), .de(de),
        .forwardA(forwardA), .forwardB(forwardB),
        .wb(wb), .em(em), .pcSrc(pcSrc), .pcTarget(pcTarget)
    );

    memoryStage uMemory (
        .clk(clk), .rstN(rstN), .em(em), .wb(wb)
    );

    hazardUnit uHazard (
        .rs1D(rs1D), .rs2D(rs2D), .de(de), .em(em), .wb(wb), .pcSrc(pcSrc),
        .forwardA(forwardA), .forwardB(forwardB),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
    );

    // writes to x0 are not retirements
    assign wbValid = wb.regWrite && wb.rd != 5'd0;
    assign wbRd    = wb.rd;
    assign wbData  = wb.result;

endmodule

//--- verification/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for 16 rising edges
    initial begin
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

//--- verification/riscvCoreAssert.sv
`timescale 1ns/1ps

module riscvCoreAssert (
    input logic       clk,
    input logic       rstN,
    input logic       wbValid,
    input logic [4:0] wbRd,
    input logic       stallF,
    input logic       stallD,
    input logic       flushD
);

    // nothing retires while the core is held in reset
    resetQuiet: assert property (@(posedge clk) !rstN |=> !wbValid)
        else $error("wbValid high during reset");

    // writes to x0 never reach the port
    noZeroRd: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wbRd != 5'd0)
        else $error("retirement reported for x0");

    // fetch holds only together with decode, and not during a flush
    stallPair: assert property (@(posedge clk) disable iff (!rstN)
        stallF |-> (stallD && !flushD))
        else $error("stallF without stallD or together with flushD");

endmodule

bind riscvCore riscvCoreAssert uAssert (
    .clk(clk), .rstN(rstN), .wbValid(wbValid), .wbRd(wbRd),
    .stallF(stallF), .stallD(stallD), .flushD(flushD)
);

//--- verification/riscvCoreTb.sv
`timescale 1ns/1ps

module riscvCoreTb;

    localparam int progLen = 39;
    localparam int expLen = 21;
    // one word per cycle plus stalls and flushes and some margin
    localparam int timeoutCycles = progLen * 4 + 40;
    localparam int drainCycles = 8;

    logic        clk;
    logic        rstN;
    logic        progWe;
    logic [5:0]  progAddr;
    logic [31:0] progData;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    int matched;
    int cycles;

    // index is the word address
    logic [31:0] progWords [progLen] = '{
        32'h0050_0093, // 00 addi x1, x0, 5
        32'hFFD0_0113, // 04 addi x2, x0, -3
        32'h0020_81B3, // 08 add  x3, x1, x2
        32'h4011_8233, // 0c sub  x4, x3, x1
        32'h4012_52B3, // 10 sra  x5, x4, x1
        32'h0040_B333, // 14 sltu x6, x1, x4
        32'h0012_23B3, // 18 slt  x7, x4, x1
        32'h0F02_C413, // 1c xori x8, x5, 0xf0
        32'h0040_9493, // 20 slli x9, x1, 4
        32'h0084_5513, // 24 srli x10, x8, 8
        32'h4012_5593, // 28 srai x11, x4, 1
        32'h0064_E633, // 2c or   x12, x9, x6
        32'h0086_76B3, // 30 and  x13, x12, x8
        32'h0084_A823, // 34 sw   x8, 16(x9)
        32'h0600_2703, // 38 lw   x14, 0x60(x0)
        32'h0017_0793, // 3c addi x15, x14, 1
        32'h0073_0663, // 40 beq  x6, x7, +12
        32'h1110_0813, // 44 addi x16, x0, 0x111 (skipped)
        32'h2220_0893, // 48 addi x17, x0, 0x222 (skipped)
        32'h0012_4663, // 4c blt  x4, x1, +12
        32'h3330_0813, // 50 addi x16, x0, 0x333 (skipped)
        32'h4440_0893, // 54 addi x17, x0, 0x444 (skipped)
        32'h0073_1463, // 58 bne  x6, x7, +8
        32'h5550_0813, // 5c addi x16, x0, 0x555
        32'h00C0_08EF, // 60 jal  x17, +12
        32'h6660_0913, // 64 addi x18, x0, 0x666 (skipped)
        32'h7770_0913, // 68 addi x18, x0, 0x777 (skipped)
        32'h1234_59B7, // 6c lui  x19, 0x12345
        32'h6789_8A13, // 70 addi x20, x19, 0x678
        32'h0218_8AE7, // 74 jalr x21, 33(x17)
        32'h8880_0B13, // 78 addi x22, x0, 0x888 (skipped)
        32'h9990_0B13, // 7c addi x22, x0, 0x999 (skipped)
        32'h7AA0_0B13, // 80 addi x22, x0, 0x7aa (skipped)
        32'h1230_0013, // 84 addi x0, x0, 0x123
        32'h0010_8033, // 88 add  x0, x1, x1
        32'h0140_0BB3, // 8c add  x23, x0, x20
        32'h0000_006F, // 90 jal  x0, 0
        32'h0BB0_0C13, // 94 addi x24, x0, 0xbb (skipped)
        32'h0CC0_0C93  // 98 addi x25, x0, 0xcc (skipped)
    };

    // retirements in order as {rd, data}
    logic [36:0] expected [expLen] = '{
        {5'd1,  32'h0000_0005}, {5'd2,  32'hFFFF_FFFD}, {5'd3,  32'h0000_0002},
        {5'd4,  32'hFFFF_FFFD}, {5'd5,  32'hFFFF_FFFF}, {5'd6,  32'h0000_0001},
        {5'd7,  32'h0000_0001}, {5'd8,  32'hFFFF_FF0F}, {5'd9,  32'h0000_0050},
        {5'd10, 32'h00FF_FFFF}, {5'd11, 32'hFFFF_FFFE}, {5'd12, 32'h0000_0051},
        {5'd13, 32'h0000_0001}, {5'd14, 32'hFFFF_FF0F}, {5'd15, 32'hFFFF_FF10},
        {5'd16, 32'h0000_0555}, {5'd17, 32'h0000_0064}, {5'd19, 32'h1234_5000},
        {5'd20, 32'h1234_5678}, {5'd21, 32'h0000_0078}, {5'd23, 32'h1234_5678}
    };

    clockGen uClock (.clk(clk), .rstN(rstN));

    riscvCore uut (
        .clk(clk), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
    );

    task automatic stopWithFailure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] want
    );
        if (got !== want) begin
            $display("** Error: %s got 0x%08h, expected 0x%08h", name, got, want);
            stopWithFailure();
        end
    endtask

    // later words still land well ahead of fetch
    initial begin
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= 6'(i);
            progData <= progWords[i];
        end
        @(posedge clk);
        progWe <= 1'b0;
    end

    initial begin
        matched = 0;
        cycles  = 0;
        @(posedge clk);
        while (matched < expLen) begin
            @(negedge clk);
            if (!rstN) begin
                checkValue("wbValid in reset", {31'b0, wbValid}, 32'h0);
            end else begin
                cycles++;
                if (cycles > timeoutCycles) begin
                    $display("Timeout: the core stopped retiring after %0d of %0d results",
                             matched, expLen);
                    stopWithFailure();
                end
                if (wbValid) begin
                    checkValue($sformatf("wbRd[%0d]", matched), {27'b0, wbRd},
                               {27'b0, expected[matched][36:32]});
                    checkValue($sformatf("wbData[%0d]", matched), wbData,
                               expected[matched][31:0]);
                    matched++;
                end
            end
        end
        // the closing self loop must stay silent
        repeat (drainCycles) begin
            @(negedge clk);
            if (wbValid) begin
                $display("Unexpected retirement of x%0d after the last expected result", wbRd);
                stopWithFailure();
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- riscvCore.f
src/rvPkg.sv
src/pipeIf.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/hazardUnit.sv
src/riscvCore.sv
verification/clockGen.sv
verification/riscvCoreAssert.sv
verification/riscvCoreTb.sv

//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := riscvCoreTb
FILELIST  := riscvCore.f
BUILDDIR  := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR) -o $(TOP)

run: build
	-./$(BUILDDIR)/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)
